/* Makefile */
VERILATOR ?= verilator
TOP       ?= rv_core_tb
FLAGS     ?= --binary --timing --assert -j 0
OBJ       ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f src.f -Mdir $(OBJ)

# Pass only if the simulation printed the pass line
run: compile
	@out="$$(./$(OBJ)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ)

/* hw/rv_alu.sv */
`timescale 1ns/100ps

module rv_alu (
    input  logic              clk,
    input  rv_pkg::alu_op_e   alu_op,
    input  rv_pkg::src_a_e    src_a,
    input  rv_pkg::src_b_e    src_b,
    input  logic [31:0]       pc,
    input  logic [31:0]       rs1_data,
    input  logic [31:0]       rs2_data,
    input  logic [31:0]       imm,
    output logic [31:0]       result,
    output logic              zero,
    output logic              lt,
    output logic              ltu
);

    logic [31:0] a, b;
    logic [31:0] y;

    // Operand select
    assign a = (src_a == rv_pkg::SRC_A_PC) ? pc : rs1_data;

    always_comb begin
        case (src_b)
            rv_pkg::SRC_B_RS2:  b = rs2_data;
            rv_pkg::SRC_B_FOUR: b = 32'd4;
            default:            b = imm;
        endcase
    end

    always_comb begin
        case (alu_op)
            rv_pkg::ALU_SUB: y = a - b;
            rv_pkg::ALU_AND: y = a & b;
            rv_pkg::ALU_OR:  y = a | b;
            rv_pkg::ALU_XOR: y = a ^ b;
            rv_pkg::ALU_SLL: y = a << b[4:0];
            rv_pkg::ALU_SRL: y = a >> b[4:0];
            rv_pkg::ALU_SRA: y = $signed(a) >>> b[4:0]; // Sign fill
            default:         y = a + b;
        endcase
    end

    // Result and flags registered, inputs hold steady after DECODE
    always_ff @(posedge clk) begin
        result <= y;
        zero   <= (y == 32'b0);             // Meaningful for SUB only
        lt     <= $signed(a) < $signed(b);
        ltu    <= a < b;
    end

endmodule

/* hw/rv_control.sv */
`timescale 1ns/100ps

module rv_control (
    input  logic               clk,
    input  logic               reset,
    input  rv_pkg::instr_t     instr,
    input  logic               zero,
    input  logic               lt,
    input  logic               ltu,
    input  logic               mem_done,
    output logic               fetch_load,
    output logic               pc_load,
    output rv_pkg::pc_sel_e    pc_sel,
    output rv_pkg::alu_op_e    alu_op,
    output rv_pkg::src_a_e     src_a,
    output rv_pkg::src_b_e     src_b,
    output logic               reg_we,
    output logic               mem_req,
    output logic               mem_we,
    output rv_pkg::wb_sel_e    wb_sel
);

    rv_pkg::state_e  state;
    rv_pkg::opcode_e opcode;
    logic [2:0]      funct3;
    logic            alt;      // funct7[5], SUB and SRA select
    logic            is_mem;
    logic            has_rd;   // Instruction writes rd
    logic            take;     // Branch condition met
    logic            late;     // MEMORY or WRITEBACK

    assign opcode = instr.r_fmt.opcode;
    assign funct3 = instr.r_fmt.funct3;
    assign alt    = instr.r_fmt.funct7[5];
    assign is_mem = (opcode == rv_pkg::OPC_LOAD) || (opcode == rv_pkg::OPC_STORE);
    assign late   = (state == rv_pkg::ST_MEMORY) || (state == rv_pkg::ST_WRITEBACK);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= rv_pkg::ST_IDLE;
        end else begin
            case (state)
                rv_pkg::ST_IDLE:    state <= rv_pkg::ST_FETCH;   // imem settles on new PC
                rv_pkg::ST_FETCH:   state <= rv_pkg::ST_DECODE;
                rv_pkg::ST_DECODE:  state <= rv_pkg::ST_EXECUTE;
                rv_pkg::ST_EXECUTE: state <= rv_pkg::ST_MEMORY;
                rv_pkg::ST_MEMORY: begin
                    // Hold here until the data bus transfer
                    if (!is_mem || mem_done) state <= rv_pkg::ST_WRITEBACK;
                end
                default:            state <= rv_pkg::ST_IDLE;
            endcase
        end
    end

    assign fetch_load = (state == rv_pkg::ST_FETCH);
    assign pc_load    = (state == rv_pkg::ST_WRITEBACK);
    assign reg_we     = pc_load && has_rd;
    assign mem_req    = (state == rv_pkg::ST_MEMORY) && is_mem;
    assign mem_we     = (opcode == rv_pkg::OPC_STORE);

    // Decode
    always_comb begin
        alu_op = rv_pkg::ALU_ADD;
        src_a  = rv_pkg::SRC_A_RS1;
        src_b  = rv_pkg::SRC_B_IMM;
        wb_sel = rv_pkg::WB_ALU;
        has_rd = 1'b1;
        case (opcode)
            rv_pkg::OPC_OP, rv_pkg::OPC_OP_IMM: begin
                if (opcode == rv_pkg::OPC_OP) src_b = rv_pkg::SRC_B_RS2;
                case (funct3)
                    rv_pkg::F3_ADD_SUB: begin
                        // No SUBI, bit 30 is part of the immediate
                        if (opcode == rv_pkg::OPC_OP && alt) alu_op = rv_pkg::ALU_SUB;
                    end
                    rv_pkg::F3_SLL: alu_op = rv_pkg::ALU_SLL;
                    rv_pkg::F3_SLT: begin
                        alu_op = rv_pkg::ALU_SUB;
                        wb_sel = rv_pkg::WB_LT;  // Flag is the result
                    end
                    rv_pkg::F3_SLTU: begin
                        alu_op = rv_pkg::ALU_SUB;
                        wb_sel = rv_pkg::WB_LTU;
                    end
                    rv_pkg::F3_XOR: alu_op = rv_pkg::ALU_XOR;
                    rv_pkg::F3_SR:  alu_op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                    rv_pkg::F3_OR:  alu_op = rv_pkg::ALU_OR;
                    default:        alu_op = rv_pkg::ALU_AND;
                endcase
            end
            rv_pkg::OPC_LOAD:  wb_sel = rv_pkg::WB_LOAD; // Address is rs1 + imm
            rv_pkg::OPC_STORE: has_rd = 1'b0;
            rv_pkg::OPC_BRANCH: begin
                alu_op = rv_pkg::ALU_SUB;   // Compare rs1 against rs2
                src_b  = rv_pkg::SRC_B_RS2;
                has_rd = 1'b0;
            end
            rv_pkg::OPC_JAL: begin
                src_a = rv_pkg::SRC_A_PC;   // Link value PC + 4
                src_b = rv_pkg::SRC_B_FOUR;
            end
            rv_pkg::OPC_JALR: begin
                // Target first, then switch to PC + 4 for the link
                if (late) begin
                    src_a = rv_pkg::SRC_A_PC;
                    src_b = rv_pkg::SRC_B_FOUR;
                end
            end
            rv_pkg::OPC_LUI:   wb_sel = rv_pkg::WB_IMM;
            rv_pkg::OPC_AUIPC: src_a  = rv_pkg::SRC_A_PC;
            default:           has_rd = 1'b0; // Unknown opcode does nothing
        endcase
    end

    // Branch decision and next-PC select
    always_comb begin
        case (funct3)
            rv_pkg::F3_BEQ:  take = zero;
            rv_pkg::F3_BNE:  take = !zero;
            rv_pkg::F3_BLT:  take = lt;
            rv_pkg::F3_BGE:  take = !lt;
            rv_pkg::F3_BLTU: take = ltu;
            rv_pkg::F3_BGEU: take = !ltu;
            default:         take = 1'b0;
        endcase
        case (opcode)
            rv_pkg::OPC_BRANCH: pc_sel = take ? rv_pkg::PC_REL : rv_pkg::PC_SEQ;
            rv_pkg::OPC_JAL:    pc_sel = rv_pkg::PC_REL;
            rv_pkg::OPC_JALR:   pc_sel = rv_pkg::PC_ALU_TGT;
            default:            pc_sel = rv_pkg::PC_SEQ;
        endcase
    end

endmodule

/* hw/rv_core.sv */
`timescale 1ns/100ps

module rv_core #(
    parameter logic [31:0] RESET_PC = 32'h0
) (
    input  logic        clk,
    input  logic        reset,
    output logic [31:0] imem_addr,
    input  logic [31:0] imem_rdata,
    output logic        dmem_valid,
    input  logic        dmem_ready,
    output logic        dmem_we,
    output logic [31:0] dmem_addr,
    output logic [31:0] dmem_wdata,
    input  logic [31:0] dmem_rdata
);

    logic [31:0]     pc;
    rv_pkg::instr_t  instr;
    logic [31:0]     imm;
    logic [31:0]     rs1_data, rs2_data; // Register read data
    logic [31:0]     alu_result;
    logic            zero, lt, ltu;      // Registered ALU flags
    logic [31:0]     rd_data;            // Write-back value

    // Control to datapath
    logic                fetch_load, pc_load;
    rv_pkg::pc_sel_e     pc_sel;
    rv_pkg::alu_op_e     alu_op;
    rv_pkg::src_a_e      src_a;
    rv_pkg::src_b_e      src_b;
    logic                reg_we;
    logic                mem_req, mem_we, mem_done;
    rv_pkg::wb_sel_e     wb_sel;

    // Input side
    rv_fetch #(.RESET_PC(RESET_PC)) fetch_inst (
        .clk        (clk),
        .reset      (reset),
        .fetch_load (fetch_load),
        .pc_load    (pc_load),
        .pc_sel     (pc_sel),
        .imm        (imm),
        .alu_result (alu_result),
        .imem_rdata (imem_rdata),
        .pc         (pc),
        .imem_addr  (imem_addr),
        .instr      (instr)
    );

    // Processing part
    rv_control control_inst (
        .clk        (clk),
        .reset      (reset),
        .instr      (instr),
        .zero       (zero),
        .lt         (lt),
        .ltu        (ltu),
        .mem_done   (mem_done),
        .fetch_load (fetch_load),
        .pc_load    (pc_load),
        .pc_sel     (pc_sel),
        .alu_op     (alu_op),
        .src_a      (src_a),
        .src_b      (src_b),
        .reg_we     (reg_we),
        .mem_req    (mem_req),
        .mem_we     (mem_we),
        .wb_sel     (wb_sel)
    );

    rv_imm_gen imm_gen_inst (
        .instr (instr),
        .imm   (imm)
    );

    rv_regfile regfile_inst (
        .clk      (clk),
        .rs1_addr (instr.r_fmt.rs1), // Indices straight from the IR
        .rs2_addr (instr.r_fmt.rs2),
        .rd_addr  (instr.r_fmt.rd),
        .we       (reg_we),
        .rd_data  (rd_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    rv_alu alu_inst (
        .clk      (clk),
        .alu_op   (alu_op),
        .src_a    (src_a),
        .src_b    (src_b),
        .pc       (pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .imm      (imm),
        .result   (alu_result),
        .zero     (zero),
        .lt       (lt),
        .ltu      (ltu)
    );

    // Output side
    rv_lsu lsu_inst (
        .clk        (clk),
        .reset      (reset),
        .mem_req    (mem_req),
        .mem_we     (mem_we),
        .wb_sel     (wb_sel),
        .alu_result (alu_result),
        .rs2_data   (rs2_data),
        .imm        (imm),
        .lt         (lt),
        .ltu        (ltu),
        .dmem_ready (dmem_ready),
        .dmem_rdata (dmem_rdata),
        .mem_done   (mem_done),
        .dmem_valid (dmem_valid),
        .dmem_we    (dmem_we),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .rd_data    (rd_data)
    );

endmodule

/* hw/rv_fetch.sv */
`timescale 1ns/100ps

module rv_fetch #(
    parameter logic [31:0] RESET_PC = 32'h0
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               fetch_load,
    input  logic               pc_load,
    input  rv_pkg::pc_sel_e    pc_sel,
    input  logic [31:0]        imm,
    input  logic [31:0]        alu_result,
    input  logic [31:0]        imem_rdata,
    output logic [31:0]        pc,
    output logic [31:0]        imem_addr,
    output rv_pkg::instr_t     instr
);

    logic [31:0] next_pc;
    logic [31:0] jalr_tgt; // ALU result one cycle old, LSB cleared

    assign imem_addr = pc;

    // JALR sum is on the ALU output during MEMORY, link value follows in WRITEBACK
    always_ff @(posedge clk) begin
        jalr_tgt <= {alu_result[31:1], 1'b0};
    end

    always_comb begin
        case (pc_sel)
            rv_pkg::PC_REL:     next_pc = pc + imm; // Taken branch, JAL
            rv_pkg::PC_ALU_TGT: next_pc = jalr_tgt;
            default:            next_pc = pc + 32'd4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (pc_load) begin
            pc <= next_pc;
        end
    end

    // Instruction register
    always_ff @(posedge clk) begin
        if (fetch_load) instr <= imem_rdata;
    end

endmodule

/* hw/rv_imm_gen.sv */
`timescale 1ns/100ps

module rv_imm_gen (
    input  rv_pkg::instr_t instr,
    output logic [31:0]    imm
);

    always_comb begin
        case (instr.r_fmt.opcode)
            rv_pkg::OPC_OP_IMM, rv_pkg::OPC_LOAD, rv_pkg::OPC_JALR: begin
                imm = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
            end
            rv_pkg::OPC_STORE: begin
                imm = {{20{instr.s_fmt.imm_11_5[6]}}, instr.s_fmt.imm_11_5,
                       instr.s_fmt.imm_4_0};
            end
            rv_pkg::OPC_BRANCH: begin
                // Halfword offset, bit 0 always zero
                imm = {{19{instr.b_fmt.imm_12}}, instr.b_fmt.imm_12, instr.b_fmt.imm_11,
                       instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1, 1'b0};
            end
            rv_pkg::OPC_LUI, rv_pkg::OPC_AUIPC: begin
                imm = {instr.u_fmt.imm_31_12, 12'b0}; // Upper 20 bits
            end
            rv_pkg::OPC_JAL: begin
                imm = {{11{instr.j_fmt.imm_20}}, instr.j_fmt.imm_20, instr.j_fmt.imm_19_12,
                       instr.j_fmt.imm_11, instr.j_fmt.imm_10_1, 1'b0};
            end
            default: imm = 32'b0; // R-type has none
        endcase
    end

endmodule

/* hw/rv_lsu.sv */
`timescale 1ns/100ps

module rv_lsu (
    input  logic              clk,
    input  logic              reset,
    input  logic              mem_req,
    input  logic              mem_we,
    input  rv_pkg::wb_sel_e   wb_sel,
    input  logic [31:0]       alu_result,
    input  logic [31:0]       rs2_data,
    input  logic [31:0]       imm,
    input  logic              lt,
    input  logic              ltu,
    input  logic              dmem_ready,
    input  logic [31:0]       dmem_rdata,
    output logic              mem_done,
    output logic              dmem_valid,
    output logic              dmem_we,
    output logic [31:0]       dmem_addr,
    output logic [31:0]       dmem_wdata,
    output logic [31:0]       rd_data
);

    logic [31:0] load_data;

    assign mem_done = dmem_valid && dmem_ready; // Transfer cycle

    // Valid rises the cycle after the request, drops after the transfer
    always_ff @(posedge clk) begin
        if (reset) begin
            dmem_valid <= 1'b0;
            dmem_we    <= 1'b0;
        end else if (mem_done) begin
            dmem_valid <= 1'b0;
            dmem_we    <= 1'b0;
        end else if (mem_req && !dmem_valid) begin
            dmem_valid <= 1'b1;
            dmem_we    <= mem_we;
        end
    end

    // Request payload latched at launch, held while stalled
    always_ff @(posedge clk) begin
        if (mem_req && !dmem_valid) begin
            dmem_addr  <= alu_result; // Word access, low bits as computed
            dmem_wdata <= rs2_data;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_done) load_data <= dmem_rdata;
    end

    // Write-back select
    always_comb begin
        case (wb_sel)
            rv_pkg::WB_LT:   rd_data = {31'b0, lt};
            rv_pkg::WB_LTU:  rd_data = {31'b0, ltu};
            rv_pkg::WB_IMM:  rd_data = imm;        // LUI
            rv_pkg::WB_LOAD: rd_data = load_data;
            default:         rd_data = alu_result;
        endcase
    end

endmodule

/* hw/rv_pkg.sv */
package rv_pkg;

    // Base opcodes of the kept RV32I subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_e;

    // funct3 for OP / OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101; // SRL or SRA, funct7[5] decides
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct3 for conditional branches
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SRA = 3'd7
    } alu_op_e;

    typedef enum logic [1:0] {SRC_A_PC = 2'd0, SRC_A_RS1 = 2'd1} src_a_e;
    typedef enum logic [1:0] {SRC_B_RS2 = 2'd0, SRC_B_IMM = 2'd1, SRC_B_FOUR = 2'd2} src_b_e;
    typedef enum logic [1:0] {PC_SEQ = 2'd0, PC_REL = 2'd1, PC_ALU_TGT = 2'd2} pc_sel_e;

    typedef enum logic [2:0] {
        WB_ALU  = 3'd0,
        WB_LT   = 3'd1,
        WB_LTU  = 3'd2,
        WB_IMM  = 3'd3,
        WB_LOAD = 3'd4
    } wb_sel_e;

    typedef enum logic [2:0] {
        ST_IDLE      = 3'd0,
        ST_FETCH     = 3'd1,
        ST_DECODE    = 3'd2,
        ST_EXECUTE   = 3'd3,
        ST_MEMORY    = 3'd4,
        ST_WRITEBACK = 3'd5
    } state_e;

    // Instruction formats, MSB first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        opcode_e    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_e    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        opcode_e     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        opcode_e    opcode;
    } j_fmt_t;

    // One word, six views
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_t;

endpackage

/* hw/rv_regfile.sv */
`timescale 1ns/100ps

module rv_regfile (
    input  logic        clk,
    input  logic [4:0]  rs1_addr,
    input  logic [4:0]  rs2_addr,
    input  logic [4:0]  rd_addr,
    input  logic        we,
    input  logic [31:0] rd_data,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data
);

    logic [31:0] regs [32];

    // x0 never written
    always_ff @(posedge clk) begin
        if (we && rd_addr != 5'd0) regs[rd_addr] <= rd_data;
    end

    // Async read, x0 forced to zero
    assign rs1_data = (rs1_addr == 5'd0) ? 32'b0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? 32'b0 : regs[rs2_addr];

endmodule

/* src.f */
+incdir+tb
hw/rv_pkg.sv
hw/rv_fetch.sv
hw/rv_control.sv
hw/rv_imm_gen.sv
hw/rv_regfile.sv
hw/rv_alu.sv
hw/rv_lsu.sv
hw/rv_core.sv
tb/rv_core_tb.sv

/* tb/rv_programs.svh */
`ifndef RV_PROGRAMS_SVH
`define RV_PROGRAMS_SVH

localparam logic [31:0] RESULT_BASE = 32'h100; // One word per checked result
localparam logic [31:0] SCRATCH     = 32'h200; // Load/store round trip
localparam logic [31:0] POISON_ADDR = 32'h3F0; // Only wrong paths store here
localparam logic [31:0] DONE_ADDR   = 32'h3FC;

// Operand values held in x1..x4
localparam logic [31:0] VAL_A   = 32'd5;
localparam logic [31:0] VAL_B   = 32'hFFFF_FFFD; // -3
localparam logic [31:0] VAL_M1  = 32'hFFFF_FFFF;
localparam logic [31:0] VAL_ONE = 32'd1;

// Instruction encoders, field order per the RV32I base formats
function automatic logic [31:0] r_type(int f7, int rs2, int rs1, int f3, int rd,
                                       rv_pkg::opcode_e op);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op};
endfunction

function automatic logic [31:0] i_type(int imm, int rs1, int f3, int rd, rv_pkg::opcode_e op);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
endfunction

function automatic logic [31:0] s_type(int imm, int rs2, int rs1);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011}; // SW
endfunction

function automatic logic [31:0] b_type(int off, int rs2, int rs1, int f3);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'b1100011};
endfunction

function automatic logic [31:0] u_type(int imm20, int rd, rv_pkg::opcode_e op);
    return {imm20[19:0], rd[4:0], op};
endfunction

function automatic logic [31:0] j_type(int off, int rd);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
endfunction

task automatic emit(logic [31:0] word);
    imem[pc_idx[7:0]] = word;
    pc_idx++;
endtask

// SW rs to the next result slot, remember what it must hold
task automatic store_result(int rs, logic [31:0] value);
    emit(s_type(RESULT_BASE + 4 * n_exp, rs, 0));
    exp_val[n_exp[5:0]] = value;
    n_exp++;
endtask

task automatic alu_case(logic [31:0] word, logic [31:0] value);
    emit(word); // Result always in x7
    store_result(7, value);
endtask

// Wrong direction runs into the poison store
task automatic branch_case(int f3, int rs1, int rs2, bit taken);
    int mk;
    mk = 'h40 + n_exp; // Marker unique per slot
    if (taken) begin
        emit(b_type(8, rs2, rs1, f3));
        emit(s_type(POISON_ADDR, 0, 0));
        emit(i_type(mk, 0, 0, 7, rv_pkg::OPC_OP_IMM));
    end else begin
        emit(b_type(12, rs2, rs1, f3));
        emit(i_type(mk, 0, 0, 7, rv_pkg::OPC_OP_IMM));
        emit(j_type(8, 0));              // Hop over the poison store
        emit(s_type(POISON_ADDR, 0, 0));
    end
    store_result(7, mk);
endtask

`endif

/* tb/rv_core_tb.sv */
`timescale 1ns/100ps

module rv_core_tb;

    localparam int MAX_CYCLES = 2000; // ~110 instructions, 6 cycles plus up to 5 on stores

    logic        clk;
    logic        reset;
    logic [31:0] imem_addr, imem_rdata;
    logic        dmem_valid, dmem_ready, dmem_we;
    logic [31:0] dmem_addr, dmem_wdata, dmem_rdata;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] exp_val [64];
    bit          seen [64];
    int          pc_idx, n_exp, n_seen;
    int          stall, cycles;
    bit          done;
    // Previous-edge bus state for the stability check
    logic        prev_valid, prev_ready, prev_we, prev_reset;
    logic [31:0] prev_addr, prev_wdata;

    `include "rv_programs.svh"

    rv_core #(.RESET_PC(32'h0)) rv_core_inst (
        .clk        (clk),
        .reset      (reset),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .dmem_valid (dmem_valid),
        .dmem_ready (dmem_ready),
        .dmem_we    (dmem_we),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata)
    );

    task automatic fail_run(string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic build_program();
        int a;
        pc_idx = 0;
        n_exp  = 0;
        emit(i_type(VAL_A, 0, 0, 1, rv_pkg::OPC_OP_IMM));   // x1 = 5
        emit(i_type(VAL_B, 0, 0, 2, rv_pkg::OPC_OP_IMM));   // x2 = -3
        emit(i_type(VAL_M1, 0, 0, 3, rv_pkg::OPC_OP_IMM));  // x3 = -1
        emit(i_type(VAL_ONE, 0, 0, 4, rv_pkg::OPC_OP_IMM)); // x4 = 1
        alu_case(r_type(0, 2, 1, 0, 7, rv_pkg::OPC_OP), 32'd2);            // 5 + -3
        alu_case(r_type('h20, 2, 1, 0, 7, rv_pkg::OPC_OP), 32'd8);         // 5 - -3
        alu_case(r_type(0, 2, 1, 7, 7, rv_pkg::OPC_OP), 32'd5);
        alu_case(r_type(0, 2, 1, 6, 7, rv_pkg::OPC_OP), 32'hFFFF_FFFD);
        alu_case(r_type(0, 2, 1, 4, 7, rv_pkg::OPC_OP), 32'hFFFF_FFF8);
        alu_case(r_type(0, 4, 1, 1, 7, rv_pkg::OPC_OP), 32'd10);
        alu_case(r_type(0, 4, 2, 5, 7, rv_pkg::OPC_OP), 32'h7FFF_FFFE);    // Zero fill
        alu_case(r_type('h20, 4, 2, 5, 7, rv_pkg::OPC_OP), 32'hFFFF_FFFE); // Sign fill
        alu_case(r_type(0, 4, 3, 2, 7, rv_pkg::OPC_OP), 32'd1);            // -1 < 1 signed
        alu_case(r_type(0, 4, 3, 3, 7, rv_pkg::OPC_OP), 32'd0);
        alu_case(i_type(-7, 1, 0, 7, rv_pkg::OPC_OP_IMM), 32'hFFFF_FFFE);
        alu_case(i_type('h0FF, 2, 7, 7, rv_pkg::OPC_OP_IMM), 32'h0000_00FD);
        alu_case(i_type('h700, 1, 6, 7, rv_pkg::OPC_OP_IMM), 32'h0000_0705);
        alu_case(i_type('h0F0, 1, 4, 7, rv_pkg::OPC_OP_IMM), 32'h0000_00F5);
        alu_case(i_type(3, 1, 1, 7, rv_pkg::OPC_OP_IMM), 32'd40);
        alu_case(i_type(28, 2, 5, 7, rv_pkg::OPC_OP_IMM), 32'h0000_000F);
        alu_case(i_type('h402, 2, 5, 7, rv_pkg::OPC_OP_IMM), 32'hFFFF_FFFF); // SRAI 2
        alu_case(i_type(1, 3, 2, 7, rv_pkg::OPC_OP_IMM), 32'd1);
        alu_case(i_type(1, 3, 3, 7, rv_pkg::OPC_OP_IMM), 32'd0);
        branch_case(0, 1, 1, 1);  // BEQ
        branch_case(0, 1, 2, 0);
        branch_case(1, 1, 2, 1);  // BNE
        branch_case(1, 1, 1, 0);
        branch_case(4, 3, 4, 1);  // BLT, -1 < 1
        branch_case(4, 4, 3, 0);
        branch_case(5, 4, 3, 1);  // BGE
        branch_case(5, 3, 4, 0);
        branch_case(6, 4, 3, 1);  // BLTU, 1 < 0xFFFFFFFF
        branch_case(6, 3, 4, 0);
        branch_case(7, 3, 4, 1);  // BGEU
        branch_case(7, 4, 3, 0);
        a = 4 * pc_idx;
        emit(j_type(8, 9));                  // JAL x9, skip poison
        emit(s_type(POISON_ADDR, 0, 0));
        store_result(9, a + 4);
        a = 4 * pc_idx;
        emit(i_type(a + 13, 0, 0, 10, rv_pkg::OPC_OP_IMM)); // Odd target
        emit(i_type(0, 10, 0, 11, rv_pkg::OPC_JALR));
        emit(s_type(POISON_ADDR, 0, 0));
        store_result(11, a + 8);
        emit(u_type('h12345, 12, rv_pkg::OPC_LUI));
        store_result(12, 32'h1234_5000);
        a = 4 * pc_idx;
        emit(u_type(1, 13, rv_pkg::OPC_AUIPC));
        store_result(13, a + 32'h1000);
        store_result(0, 32'h0);              // x0 reads zero
        emit(s_type(SCRATCH, 2, 0));
        emit(i_type(SCRATCH, 0, 2, 14, rv_pkg::OPC_LOAD));
        store_result(14, VAL_B);
        emit(s_type(SCRATCH + 4, 12, 0));
        emit(i_type(SCRATCH + 4, 0, 2, 15, rv_pkg::OPC_LOAD));
        store_result(15, 32'h1234_5000);
        emit(s_type(DONE_ADDR, 4, 0));
        emit(j_type(0, 0));                  // Spin
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Synchronous instruction memory, one cycle latency
    always @(posedge clk) imem_rdata <= imem[imem_addr[9:2]];

    // Data memory with random wait states before ready
    always @(posedge clk) begin
        if (reset) begin
            dmem_ready <= 1'b0;
        end else if (dmem_valid && dmem_ready) begin
            if (dmem_we) dmem[dmem_addr[9:2]] <= dmem_wdata;
            dmem_ready <= 1'b0;
            stall      <= $urandom_range(3, 0);
        end else if (dmem_valid) begin
            if (stall == 0) begin
                dmem_ready <= 1'b1;
                dmem_rdata <= dmem[dmem_addr[9:2]];
            end else begin
                stall <= stall - 1;
            end
        end
    end

    // Bus checks at every edge
    always @(posedge clk) begin
        int idx;
        cycles <= cycles + 1;
        if (reset && prev_reset)
            assert (dmem_valid == 1'b0)
                else fail_run($sformatf("FAILED dmem_valid during reset: got %h, expected 0",
                                        dmem_valid));
        if (!reset) begin
            // Every fetch address is word aligned, odd JALR targets included
            assert (imem_addr[1:0] == 2'b00)
                else fail_run($sformatf("FAILED imem_addr: got %h, expected low bits 00",
                                        imem_addr));
        end
        if (!reset && prev_valid && !prev_ready) begin
            assert (dmem_valid)
                else fail_run($sformatf("FAILED dmem_valid under stall: got %h, expected 1",
                                        dmem_valid));
            assert (dmem_addr == prev_addr && dmem_we == prev_we && dmem_wdata == prev_wdata)
                else fail_run($sformatf(
                    "FAILED dmem_addr/dmem_we/dmem_wdata under stall: got %h/%h/%h, expected %h/%h/%h",
                    dmem_addr, dmem_we, dmem_wdata, prev_addr, prev_we, prev_wdata));
        end
        if (!reset && dmem_valid && dmem_ready && dmem_we) begin
            assert (dmem_addr != POISON_ADDR) else fail_run("Store to the poison address");
            if (dmem_addr >= RESULT_BASE && dmem_addr < RESULT_BASE + 4 * n_exp) begin
                idx = (dmem_addr - RESULT_BASE) >> 2;
                assert (dmem_wdata == exp_val[idx[5:0]])
                    else fail_run($sformatf("FAILED dmem_wdata at %h: got %h, expected %h",
                                            dmem_addr, dmem_wdata, exp_val[idx[5:0]]));
                if (!seen[idx[5:0]]) n_seen++;
                seen[idx[5:0]] = 1'b1;
            end
            if (dmem_addr == DONE_ADDR) begin
                assert (n_seen == n_exp)
                    else fail_run($sformatf("FAILED n_seen at done store: got %h, expected %h",
                                            n_seen, n_exp));
                done = 1'b1;
            end
        end
        prev_reset = reset;
        prev_valid = dmem_valid;
        prev_ready = dmem_ready;
        prev_we    = dmem_we;
        prev_addr  = dmem_addr;
        prev_wdata = dmem_wdata;
    end

    initial begin
        void'($urandom(32'ha5ca));
        reset      = 1'b1;
        imem_rdata = 32'h0;
        dmem_ready = 1'b0;
        dmem_rdata = 32'h0;
        stall = 0;
        cycles = 0;
        done = 1'b0;
        n_seen = 0;
        prev_reset = 1'b0;
        prev_valid = 1'b0;
        prev_ready = 1'b0;
        for (int i = 0; i < 256; i++) begin
            imem[i[7:0]] = i_type(i, 0, 0, 0, rv_pkg::OPC_OP_IMM); // NOP, imm is the index
            dmem[i[7:0]] = 32'hC0DE_0000 ^ (i * 4);
        end
        for (int i = 0; i < 64; i++) seen[i[5:0]] = 1'b0;
        build_program();
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        while (!done && cycles < MAX_CYCLES) @(posedge clk);
        if (done) begin
            $display("Test passed");
            $finish;
        end else begin
            fail_run($sformatf("Timeout after %0d cycles without the done store", cycles));
        end
    end

endmodule
